//--- compile.f
common/sram_ctrl_pkg.sv
sram_ctrl/sram_req_decoder.sv
sram_ctrl/sram_half_merge.sv
sram_ctrl/sram_cycle_fsm.sv
hw/sram_ctrl_top.sv
tests/tb_sram_model.sv
tests/tb_sram_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# Build the SRAM controller testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f compile.f --top-module tb_sram_ctrl -o tb_sram_ctrl ||
    { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_sram_ctrl 2>&1 | tee /dev/stderr | grep "Done: no errors" > /dev/null &&
    echo "PASS" || { echo "FAIL"; exit 1; }

//--- tests/tb_sram_ctrl.sv
//========================================
// Testbench for the SRAM controller
// Shadow memory gives every expected value
//========================================
`timescale 1ns/1ps
`default_nettype none

module tb_sram_ctrl;

    import sram_ctrl_pkg::*;

    localparam int addr_w   = 18;
    localparam int num_rows = 15;
    localparam int clk_half = 50;

    localparam logic [addr_w-1:0] addr_one = 1;

    // One CPU request; rnd replaces data with LFSR bits
    typedef struct packed {
        logic        rnd;
        strb_t       strb;
        logic [31:0] addr;
        word_t       data;
    } row_t;

    //========================================
    // Stimulus table
    //========================================
    row_t rows [num_rows] = '{
        '{1'b0, 4'b1111, 32'h0000_0100, 32'hdead_beef},
        '{1'b0, 4'b0000, 32'h0000_0100, 32'h0},
        '{1'b1, 4'b0011, 32'h0000_0100, 32'h0},
        '{1'b1, 4'b1100, 32'h0000_0100, 32'h0},
        '{1'b0, 4'b0000, 32'h0000_0100, 32'h0},
        // Untouched location, odd halfword address
        '{1'b0, 4'b0000, 32'h0000_0202, 32'h0},
        '{1'b1, 4'b0001, 32'h0000_0202, 32'h0},
        '{1'b1, 4'b0010, 32'h0000_0202, 32'h0},
        '{1'b1, 4'b0100, 32'h0000_0202, 32'h0},
        '{1'b1, 4'b1000, 32'h0000_0202, 32'h0},
        '{1'b0, 4'b0000, 32'h0000_0202, 32'h0},
        '{1'b1, 4'b0110, 32'h0000_0400, 32'h0},
        '{1'b0, 4'b0000, 32'h0000_0400, 32'h0},
        // Top location, high half wraps to zero
        '{1'b1, 4'b1001, 32'h0007_fffe, 32'h0},
        '{1'b0, 4'b0000, 32'h0007_fffe, 32'h0}
    };

    logic              clk;
    logic              resetn;
    logic              valid;
    cpu_req_t          req;
    logic              ready;
    word_t             rdata;
    logic [addr_w-1:0] sram_addr;
    sram_ctrl_t        sram_ctl;
    half_t             dq_out;
    logic              dq_oe;
    half_t             dq_in;

    logic [31:0]       lfsr;
    // High from valid until ready
    logic              busy;
    // Written halfwords only
    half_t             shadow [logic [addr_w-1:0]];

    sram_ctrl_top #(
        .sram_addr_w (addr_w)
    ) u_dut (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .req       (req),
        .ready     (ready),
        .rdata     (rdata),
        .sram_addr (sram_addr),
        .sram_ctl  (sram_ctl),
        .dq_out    (dq_out),
        .dq_oe     (dq_oe),
        .dq_in     (dq_in)
    );

    tb_sram_model u_mem (
        .clk   (clk),
        .addr  (sram_addr),
        .ctl   (sram_ctl),
        .dq    (dq_out),
        .dq_oe (dq_oe),
        .dq_in (dq_in)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_half) clk = ~clk;
    end

    //========================================
    // Reference rules
    //========================================

    // Galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_word(output word_t w);
        w = '0;
        for (int b = 0; b < word_w; b++) begin
            lfsr = galois_step(lfsr);
            w    = {w[word_w-2:0], lfsr[0]};
        end
    endtask

    // Same start pattern as the SRAM model
    function automatic half_t fill_half(input logic [addr_w-1:0] a);
        return a[15:0] ^ {6'h0, a[17:8]} ^ 16'ha5c3;
    endfunction

    function automatic half_t shadow_get(input logic [addr_w-1:0] a);
        return shadow.exists(a) ? shadow[a] : fill_half(a);
    endfunction

    // Strobed bytes replace the old bytes
    function automatic half_t put_bytes(input half_t old_h, input half_t new_h,
                                        input logic [1:0] en);
        half_t h;
        h = old_h;
        if (en[0]) h[7:0] = new_h[7:0];
        if (en[1]) h[15:8] = new_h[15:8];
        return h;
    endfunction

    // Latency table by access kind
    function automatic int expected_cycles(input strb_t s);
        if (s == 4'b0000) return 4;
        if (s == 4'b1111) return 6;
        if (s == 4'b0011 || s == 4'b1100) return 3;
        return (|s[1:0] && |s[3:2]) ? 10 : 7;
    endfunction

    // Halfwords touched by the strobes
    function automatic int expected_writes(input strb_t s);
        return (|s[1:0] ? 1 : 0) + (|s[3:2] ? 1 : 0);
    endfunction

    //========================================
    // Checks
    //========================================

    task automatic stop_on_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("Done: errors found");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) stop_on_error($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    task automatic check_half(input string what, input half_t got, input half_t exp);
        if (got !== exp) stop_on_error($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    task automatic check_cycles(input string what, input int got, input int exp);
        if (got != exp) stop_on_error($sformatf("%s got %0d expected %0d", what, got, exp));
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) stop_on_error($sformatf("%s got %0d expected %0d", what, got, exp));
    endtask

    task automatic check_ctl(input string what, input sram_ctrl_t got, input sram_ctrl_t exp);
        if (got !== exp) stop_on_error($sformatf("%s got %b expected %b", what, got, exp));
    endtask

    // Falling edge plus pin safety rules
    task automatic next_fall;
        @(negedge clk);
        if (!sram_ctl.oe_n && !sram_ctl.we_n) stop_on_error("oe_n and we_n low together");
        if (!sram_ctl.oe_n && dq_oe) stop_on_error("dq_oe high while oe_n low");
        if (!busy && !ready && !sram_ctl.cs_n) stop_on_error("cs_n low while idle");
    endtask

    //========================================
    // One transaction
    //========================================

    task automatic run_row(input row_t r);
        word_t             data;
        logic [addr_w-1:0] wa;
        logic [addr_w-1:0] wa_hi;
        word_t             exp_rd;
        int                cycles;
        int                writes_before;
        next_fall();
        data = r.data;
        if (r.rnd) random_word(data);
        wa            = r.addr[addr_w:1];
        wa_hi         = wa + addr_one;
        exp_rd        = {shadow_get(wa_hi), shadow_get(wa)};
        writes_before = u_mem.writes;
        req.addr      = r.addr;
        req.wdata     = data;
        req.wstrb     = r.strb;
        valid         = 1'b1;
        busy          = 1'b1;
        // Edges after accept until ready shows
        cycles = 0;
        next_fall();
        while (!ready) begin
            cycles++;
            next_fall();
        end
        valid = 1'b0;
        busy  = 1'b0;
        check_cycles("latency", cycles, expected_cycles(r.strb));
        check_count("halfword writes", u_mem.writes - writes_before,
                    expected_writes(r.strb));
        if (r.strb == 4'b0000) begin
            check_word("read data", rdata, exp_rd);
        end else begin
            if (|r.strb[1:0]) shadow[wa] = put_bytes(shadow_get(wa), data[15:0], r.strb[1:0]);
            if (|r.strb[3:2]) begin
                shadow[wa_hi] = put_bytes(shadow_get(wa_hi), data[31:16], r.strb[3:2]);
            end
            check_half("low halfword", u_mem.mem[wa], shadow_get(wa));
            check_half("high halfword", u_mem.mem[wa_hi], shadow_get(wa_hi));
        end
    endtask

    //========================================
    // Main sequence and watchdog
    //========================================

    initial begin
        lfsr   = 32'h7016;
        resetn = 1'b0;
        valid  = 1'b0;
        req    = '0;
        busy   = 1'b0;
        repeat (5) @(negedge clk);
        resetn = 1'b1;
        check_ctl("pins after reset", sram_ctl, 3'b111);
        check_word("rdata after reset", rdata, '0);
        if (ready !== 1'b0 || dq_oe !== 1'b0) stop_on_error("ready or dq_oe not low after reset");
        for (int i = 0; i < num_rows; i++) begin
            run_row(rows[i]);
        end
        next_fall();
        $display("Done: no errors");
        $finish;
    end

    // Longest access plus the idle cycle per row, then margin
    initial begin
        #((num_rows * 11 + 20) * 2 * clk_half);
        $display("Timeout: the controller did not finish all transactions in time");
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- tests/tb_sram_model.sv
//========================================
// Async SRAM model, 256K halfwords, fixed fill pattern
// Writes on a clock edge with cs_n and we_n low and dq_oe high
//========================================
`timescale 1ns/1ps
`default_nettype none

module tb_sram_model (
    input  wire                            clk,
    input  wire [17:0]                     addr,
    input  wire sram_ctrl_pkg::sram_ctrl_t ctl,
    input  wire sram_ctrl_pkg::half_t      dq,
    input  wire                            dq_oe,
    output sram_ctrl_pkg::half_t           dq_in
);

    import sram_ctrl_pkg::*;

    localparam int depth = 262144;

    half_t mem [depth];

    // Halfword writes seen so far
    int writes = 0;

    // Start value, every address bit takes part
    function automatic half_t fill(input logic [17:0] a);
        return a[15:0] ^ {6'h0, a[17:8]} ^ 16'ha5c3;
    endfunction

    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = fill(i[17:0]);
        end
    end

    always @(posedge clk) begin
        if (!ctl.cs_n && !ctl.we_n && dq_oe) begin
            mem[addr] = dq;
            writes++;
        end
    end

    // Output enable drives the stored halfword, bus reads zero otherwise
    assign dq_in = (!ctl.cs_n && !ctl.oe_n) ? mem[addr] : '0;

endmodule

`default_nettype wire

//--- hw/sram_ctrl_top.sv
//======================================
// CPU to async 16-bit SRAM controller
// Data bus is split, the pad lives in the board wrapper
//======================================
`timescale 1ns/1ps
`default_nettype none

module sram_ctrl_top #(
    parameter int sram_addr_w = 18
) (
    input  wire                          clk,
    input  wire                          resetn,

    // CPU side
    input  wire                          valid,
    input  wire sram_ctrl_pkg::cpu_req_t req,
    output logic                         ready,
    output sram_ctrl_pkg::word_t         rdata,

    // SRAM side
    output logic [sram_addr_w-1:0]       sram_addr,
    output sram_ctrl_pkg::sram_ctrl_t    sram_ctl,
    output sram_ctrl_pkg::half_t         dq_out,
    output logic                         dq_oe,
    input  wire sram_ctrl_pkg::half_t    dq_in
);

    import sram_ctrl_pkg::*;

    logic                   accept;
    access_kind_t           kind;
    logic [sram_addr_w-1:0] addr_low;
    logic [sram_addr_w-1:0] addr_high;
    logic                   low_hit;
    logic                   high_hit;
    word_t                  wdata;
    strb_t                  wstrb;
    logic                   cap_en;
    half_sel_t              cap_sel;
    half_t                  wr_low;
    half_t                  wr_high;

    // Request latch and strobe decode
    sram_req_decoder #(
        .sram_addr_w (sram_addr_w)
    ) u_decoder (
        .clk       (clk),
        .resetn    (resetn),
        .accept    (accept),
        .req       (req),
        .kind      (kind),
        .addr_low  (addr_low),
        .addr_high (addr_high),
        .low_hit   (low_hit),
        .high_hit  (high_hit),
        .wdata     (wdata),
        .wstrb     (wstrb)
    );

    // Read buffers and RMW merge
    sram_half_merge u_merge (
        .clk     (clk),
        .resetn  (resetn),
        .cap_en  (cap_en),
        .cap_sel (cap_sel),
        .dq_in   (dq_in),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .kind    (kind),
        .wr_low  (wr_low),
        .wr_high (wr_high),
        .rdata   (rdata)
    );

    // Pin sequencer
    sram_cycle_fsm #(
        .sram_addr_w (sram_addr_w)
    ) u_fsm (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .kind      (kind),
        .low_hit   (low_hit),
        .high_hit  (high_hit),
        .addr_low  (addr_low),
        .addr_high (addr_high),
        .wr_low    (wr_low),
        .wr_high   (wr_high),
        .accept    (accept),
        .cap_en    (cap_en),
        .cap_sel   (cap_sel),
        .ready     (ready),
        .sram_addr (sram_addr),
        .sram_ctl  (sram_ctl),
        .dq_out    (dq_out),
        .dq_oe     (dq_oe)
    );

endmodule

`default_nettype wire

//--- sram_ctrl/sram_cycle_fsm.sv
//======================================
// Single FSM for all SRAM pin sequences
// One request in flight, pins are registered, ready is a one-cycle pulse
//======================================
`timescale 1ns/1ps
`default_nettype none

module sram_cycle_fsm #(
    parameter int sram_addr_w = 18
) (
    input  wire                              clk,
    input  wire                              resetn,
    input  wire                              valid,
    input  wire sram_ctrl_pkg::access_kind_t kind,
    input  wire                              low_hit,
    input  wire                              high_hit,
    input  wire [sram_addr_w-1:0]            addr_low,
    input  wire [sram_addr_w-1:0]            addr_high,
    input  wire sram_ctrl_pkg::half_t        wr_low,
    input  wire sram_ctrl_pkg::half_t        wr_high,
    output logic                             accept,
    output logic                             cap_en,
    output sram_ctrl_pkg::half_sel_t         cap_sel,
    output logic                             ready,
    output logic [sram_addr_w-1:0]           sram_addr,
    output sram_ctrl_pkg::sram_ctrl_t        sram_ctl,
    output sram_ctrl_pkg::half_t             dq_out,
    output logic                             dq_oe
);

    import sram_ctrl_pkg::*;

    // Pin patterns
    localparam sram_ctrl_t ctl_idle  = '{cs_n: 1'b1, oe_n: 1'b1, we_n: 1'b1};
    localparam sram_ctrl_t ctl_read  = '{cs_n: 1'b0, oe_n: 1'b0, we_n: 1'b1};
    localparam sram_ctrl_t ctl_write = '{cs_n: 1'b0, oe_n: 1'b1, we_n: 1'b1};

    // Each state names the action taken at the edge that leaves it
    typedef enum logic [3:0] {
        st_idle,
        st_decode,
        st_rd_lo_cap,
        st_rd_hi_setup,
        st_rd_hi_cap,
        st_wr_lo_setup,
        st_wr_lo_pulse,
        st_wr_lo_done,
        st_wr_hi_setup,
        st_wr_hi_pulse,
        st_wr_hi_done
    } state_t;

    state_t     state_q;
    state_t     state_d;
    sram_ctrl_t ctl_d;
    logic       dq_oe_d;
    logic       ready_d;

    // Load address and data for a new halfword access
    logic       ld_addr;
    half_sel_t  ld_sel;

    //======================================
    // Handshake and capture strobes
    //======================================

    // Ready guard keeps a held valid from starting a second access
    assign accept  = (state_q == st_idle) && valid && !ready;

    assign cap_en  = (state_q == st_rd_lo_cap) || (state_q == st_rd_hi_cap);
    assign cap_sel = (state_q == st_rd_hi_cap) ? half_high : half_low;

    //======================================
    // Next state and pin values
    //======================================

    always_comb begin
        state_d = state_q;
        ctl_d   = sram_ctl;
        dq_oe_d = dq_oe;
        ready_d = 1'b0;
        ld_addr = 1'b0;
        ld_sel  = half_low;

        case (state_q)
            st_idle: begin
                ctl_d   = ctl_idle;
                dq_oe_d = 1'b0;
                if (accept) begin
                    state_d = st_decode;
                end
            end

            // Kind is valid now, first halfword setup goes out here
            st_decode: begin
                ld_addr = 1'b1;
                case (kind)
                    acc_read, acc_rmw: begin
                        ctl_d   = ctl_read;
                        dq_oe_d = 1'b0;
                        state_d = st_rd_lo_cap;
                    end
                    acc_high_half: begin
                        ld_sel  = half_high;
                        ctl_d   = ctl_write;
                        dq_oe_d = 1'b1;
                        state_d = st_wr_hi_pulse;
                    end
                    // Full word and low halfword start on the low half
                    default: begin
                        ctl_d   = ctl_write;
                        dq_oe_d = 1'b1;
                        state_d = st_wr_lo_pulse;
                    end
                endcase
            end

            // Low halfword sampled into the merge unit
            st_rd_lo_cap: begin
                state_d = st_rd_hi_setup;
            end

            st_rd_hi_setup: begin
                ld_addr = 1'b1;
                ld_sel  = half_high;
                state_d = st_rd_hi_cap;
            end

            // High halfword sampled, bus released
            st_rd_hi_cap: begin
                ctl_d = ctl_idle;
                if (kind == acc_read) begin
                    ready_d = 1'b1;
                    state_d = st_idle;
                end else if (low_hit) begin
                    state_d = st_wr_lo_setup;
                end else begin
                    state_d = st_wr_hi_setup;
                end
            end

            st_wr_lo_setup: begin
                ld_addr = 1'b1;
                ctl_d   = ctl_write;
                dq_oe_d = 1'b1;
                state_d = st_wr_lo_pulse;
            end

            st_wr_lo_pulse: begin
                ctl_d.we_n = 1'b0;
                state_d    = st_wr_lo_done;
            end

            // Full writes always have high_hit set
            st_wr_lo_done: begin
                ctl_d.we_n = 1'b1;
                if (high_hit) begin
                    state_d = st_wr_hi_setup;
                end else begin
                    ready_d = 1'b1;
                    state_d = st_idle;
                end
            end

            st_wr_hi_setup: begin
                ld_addr = 1'b1;
                ld_sel  = half_high;
                ctl_d   = ctl_write;
                dq_oe_d = 1'b1;
                state_d = st_wr_hi_pulse;
            end

            st_wr_hi_pulse: begin
                ctl_d.we_n = 1'b0;
                state_d    = st_wr_hi_done;
            end

            st_wr_hi_done: begin
                ctl_d.we_n = 1'b1;
                ready_d    = 1'b1;
                state_d    = st_idle;
            end

            default: begin
                state_d = st_idle;
            end
        endcase
    end

    //======================================
    // Registers
    //======================================

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q  <= st_idle;
            ready    <= 1'b0;
            sram_ctl <= ctl_idle;
            dq_oe    <= 1'b0;
        end else begin
            state_q  <= state_d;
            ready    <= ready_d;
            sram_ctl <= ctl_d;
            dq_oe    <= dq_oe_d;
        end
    end

    // Address and data hold from setup through write complete
    always_ff @(posedge clk) begin
        if (ld_addr) begin
            sram_addr <= (ld_sel == half_high) ? addr_high : addr_low;
            dq_out    <= (ld_sel == half_high) ? wr_high : wr_low;
        end
    end

endmodule

`default_nettype wire

//--- sram_ctrl/sram_half_merge.sv
//======================================
// Capture buffers, RMW byte merge and read word assembly
// Merge is combinational on the captured halfwords
//======================================
`timescale 1ns/1ps
`default_nettype none

module sram_half_merge (
    input  wire                              clk,
    input  wire                              resetn,
    input  wire                              cap_en,
    input  wire sram_ctrl_pkg::half_sel_t    cap_sel,
    input  wire sram_ctrl_pkg::half_t        dq_in,
    input  wire sram_ctrl_pkg::word_t        wdata,
    input  wire sram_ctrl_pkg::strb_t        wstrb,
    input  wire sram_ctrl_pkg::access_kind_t kind,
    output sram_ctrl_pkg::half_t             wr_low,
    output sram_ctrl_pkg::half_t             wr_high,
    output sram_ctrl_pkg::word_t             rdata
);

    import sram_ctrl_pkg::*;

    // Halfwords read back from the SRAM
    half_t buf_low;
    half_t buf_high;

    // Old halfword with the strobed bytes replaced
    half_t merged_low;
    half_t merged_high;

    // Byte lane merge for one halfword
    function automatic half_t merge_half(
        input half_t      old_h,
        input half_t      new_h,
        input logic [1:0] strb
    );
        half_t m;
        m[7:0]  = strb[0] ? new_h[7:0]  : old_h[7:0];
        m[15:8] = strb[1] ? new_h[15:8] : old_h[15:8];
        return m;
    endfunction

    //======================================
    // Capture
    //======================================

    always_ff @(posedge clk) begin
        if (cap_en) begin
            if (cap_sel == half_low) begin
                buf_low <= dq_in;
            end else begin
                buf_high <= dq_in;
            end
        end
    end

    // High capture of a plain read completes the word
    // Held until the next read finishes
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rdata <= '0;
        end else if (cap_en && (cap_sel == half_high) && (kind == acc_read)) begin
            rdata <= {dq_in, buf_low};
        end
    end

    //======================================
    // Write data
    //======================================

    assign merged_low  = merge_half(buf_low,  wdata[15:0],  wstrb[1:0]);
    assign merged_high = merge_half(buf_high, wdata[31:16], wstrb[3:2]);

    // Only RMW uses the captured data
    assign wr_low  = (kind == acc_rmw) ? merged_low  : wdata[15:0];
    assign wr_high = (kind == acc_rmw) ? merged_high : wdata[31:16];

endmodule

`default_nettype wire

//--- sram_ctrl/sram_req_decoder.sv
//======================================
// Latches one CPU request per accept and decodes its kind
// Request must be stable in the accept cycle
//======================================
`timescale 1ns/1ps
`default_nettype none

module sram_req_decoder #(
    parameter int sram_addr_w = 18
) (
    input  wire                          clk,
    input  wire                          resetn,
    input  wire                          accept,
    input  wire sram_ctrl_pkg::cpu_req_t req,
    output sram_ctrl_pkg::access_kind_t  kind,
    output logic [sram_addr_w-1:0]       addr_low,
    output logic [sram_addr_w-1:0]       addr_high,
    output logic                         low_hit,
    output logic                         high_hit,
    output sram_ctrl_pkg::word_t         wdata,
    output sram_ctrl_pkg::strb_t         wstrb
);

    import sram_ctrl_pkg::*;

    localparam logic [sram_addr_w-1:0] addr_one = 1;

    // Halfword address of the low half, byte offset dropped
    logic [sram_addr_w-1:0] word_addr;

    assign word_addr = req.addr[sram_addr_w:1];

    // Strobe pattern to access kind
    // Aligned halfwords go straight to the SRAM, odd patterns need RMW
    function automatic access_kind_t classify(input strb_t strb);
        access_kind_t k;
        case (strb)
            4'b0000: k = acc_read;
            4'b1111: k = acc_full_write;
            4'b0011: k = acc_low_half;
            4'b1100: k = acc_high_half;
            default: k = acc_rmw;
        endcase
        return k;
    endfunction

    //======================================
    // Decoded control
    //======================================

    always_ff @(posedge clk) begin
        if (!resetn) begin
            kind     <= acc_read;
            low_hit  <= 1'b0;
            high_hit <= 1'b0;
        end else if (accept) begin
            kind     <= classify(req.wstrb);
            // Bytes 1..0 live in the low halfword
            low_hit  <= |req.wstrb[1:0];
            // Bytes 3..2 live in the high halfword
            high_hit <= |req.wstrb[3:2];
        end
    end

    //======================================
    // Request payload
    //======================================

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_low  <= word_addr;
            // High half sits one location up, wraps at the top of the SRAM
            addr_high <= word_addr + addr_one;
            wdata     <= req.wdata;
            wstrb     <= req.wstrb;
        end
    end

endmodule

`default_nettype wire

//--- common/sram_ctrl_pkg.sv
//======================================
// Widths, request and pin types for the SRAM controller
// The SRAM address width is a module parameter and lives in the top level
//======================================
`default_nettype none

package sram_ctrl_pkg;

    //======================================
    // Bus widths
    //======================================

    // CPU side data width
    localparam int word_w = 32;

    // SRAM data width, one halfword location
    localparam int half_w = 16;

    // One strobe per CPU byte lane
    localparam int strb_w = 4;

    typedef logic [word_w-1:0] word_t;
    typedef logic [half_w-1:0] half_t;
    typedef logic [strb_w-1:0] strb_t;

    //======================================
    // CPU request
    //======================================

    // Byte address is one bus word wide
    // Bits 0 and above sram_addr_w are ignored by the controller
    typedef struct packed {
        logic [word_w-1:0] addr;
        word_t             wdata;
        strb_t             wstrb;
    } cpu_req_t;

    // Access kind decoded from the byte strobes
    typedef enum logic [2:0] {
        acc_read,
        acc_full_write,
        acc_low_half,
        acc_high_half,
        acc_rmw
    } access_kind_t;

    //======================================
    // SRAM side
    //======================================

    // Control pins, all active low
    typedef struct packed {
        logic cs_n;
        logic oe_n;
        logic we_n;
    } sram_ctrl_t;

    // Halfword currently on the SRAM bus
    typedef enum logic {
        half_low,
        half_high
    } half_sel_t;

endpackage

`default_nettype wire
